//--- src/alu_pkg.sv
package alu_pkg;

   typedef enum logic [2:0] {
      OP_NONE = 3'd0,
      OP_ADD  = 3'd1,
      OP_SUB  = 3'd2,
      OP_MUL  = 3'd3,
      OP_DIV  = 3'd4
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_IDLE      = 3'd0,
      ST_SIGN_B    = 3'd1,
      ST_MUL       = 3'd2,
      ST_DIV_SHIFT = 3'd3,
      ST_DIV_CMP   = 3'd4,
      ST_DIV_CNT   = 3'd5,
      ST_SIGN_Q    = 3'd6
   } alu_state_e;

   // operand pair presented to the shared adder
   typedef enum logic [2:0] {
      SEL_ADD     = 3'd0,
      SEL_SUB     = 3'd1,
      SEL_NEG_A   = 3'd2,
      SEL_NEG_B   = 3'd3,
      SEL_MUL_ACC = 3'd4,
      SEL_DIV_TRY = 3'd5,
      SEL_CNT_DEC = 3'd6,
      SEL_NEG_Q   = 3'd7
   } adder_sel_e;

   typedef struct packed {
      adder_sel_e adder_sel;
      logic       load_a;
      logic       load_b;
      logic       load_from_adder; // negated value instead of the raw input
      logic       clear;
      logic       mul_step;
      logic       div_shift;
      logic       div_restore;
      logic       cnt_step;
      logic       q_load;
   } dp_ctrl_t;

   typedef struct packed {
      logic a_neg;
      logic b_neg;
      logic a_rest_zero;
      logic b_msb;
      logic adder_ovf;
      logic adder_neg;
      logic cnt_zero;
   } dp_status_t;

endpackage

//--- src/alu_adder.sv
`timescale 1ns/1ps
module alu_adder #(
   parameter int DATA_WIDTH = 16
) (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf
);

   assign o_q = i_a + i_b;

   // operands of equal sign giving a sum of the other sign
   assign o_ovf = (i_a[DATA_WIDTH-1] == i_b[DATA_WIDTH-1]) &&
                  (o_q[DATA_WIDTH-1] != i_a[DATA_WIDTH-1]);

endmodule

//--- src/alu_adder_mux.sv
`timescale 1ns/1ps
module alu_adder_mux import alu_pkg::*; #(
   parameter int DATA_WIDTH = 16
) (
   input  adder_sel_e                      i_sel,
   input  logic signed [DATA_WIDTH-1:0]    i_a,
   input  logic signed [DATA_WIDTH-1:0]    i_b,
   input  logic [DATA_WIDTH-1:0]           i_areg,
   input  logic [DATA_WIDTH-1:0]           i_breg,
   input  logic [DATA_WIDTH-1:0]           i_rem,
   input  logic [DATA_WIDTH-1:0]           i_q,
   input  logic [$clog2(DATA_WIDTH)-1:0]   i_cnt,
   output logic signed [DATA_WIDTH-1:0]    o_add_a,
   output logic signed [DATA_WIDTH-1:0]    o_add_b
);

   localparam int CNT_W = $clog2(DATA_WIDTH);
   localparam logic [DATA_WIDTH-1:0] ONE = DATA_WIDTH'(1);

   logic [DATA_WIDTH-1:0] cnt_wide;

   assign cnt_wide = {{(DATA_WIDTH-CNT_W){1'b0}}, i_cnt};

   always_comb begin
      o_add_a = i_a;
      o_add_b = i_b;
      case (i_sel)
         SEL_ADD: begin
            o_add_a = i_a;
            o_add_b = i_b;
         end
         SEL_SUB: begin
            o_add_a = i_a;
            o_add_b = ~i_b + ONE;
         end
         SEL_NEG_A: begin
            o_add_a = ~i_a;
            o_add_b = ONE;
         end
         SEL_NEG_B: begin
            o_add_a = ~i_b;
            o_add_b = ONE;
         end
         SEL_MUL_ACC: begin
            o_add_a = i_q;
            o_add_b = i_breg;
         end
         SEL_DIV_TRY: begin
            o_add_a = i_rem;
            o_add_b = ~i_breg + ONE; // trial subtraction of the divisor
         end
         SEL_CNT_DEC: begin
            o_add_a = cnt_wide;
            o_add_b = '1;
         end
         SEL_NEG_Q: begin
            o_add_a = ~i_q;
            o_add_b = ONE;
         end
         default: begin
            o_add_a = i_areg; // unreachable, the enum is fully decoded
            o_add_b = i_b;
         end
      endcase
   end

endmodule

//--- src/alu_operand_regs.sv
`timescale 1ns/1ps
module alu_operand_regs import alu_pkg::*; #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                            i_clk,
   input  logic                            i_nrst,
   input  dp_ctrl_t                        i_ctrl,
   input  logic [DATA_WIDTH-1:0]           i_a,
   input  logic [DATA_WIDTH-1:0]           i_b,
   input  logic [DATA_WIDTH-1:0]           i_sum,
   input  logic                            i_sum_ovf,
   output logic [DATA_WIDTH-1:0]           o_areg,
   output logic [DATA_WIDTH-1:0]           o_breg,
   output logic [DATA_WIDTH-1:0]           o_rem,
   output logic [DATA_WIDTH-1:0]           o_q,
   output logic [$clog2(DATA_WIDTH)-1:0]   o_cnt,
   output dp_status_t                      o_status
);

   localparam int CNT_W = $clog2(DATA_WIDTH);

   logic [DATA_WIDTH-1:0] areg;
   logic [DATA_WIDTH-1:0] breg;
   logic [DATA_WIDTH-1:0] rem;
   logic [DATA_WIDTH-1:0] q;
   logic [CNT_W-1:0]      cnt;
   logic                  a_from_adder;
   logic                  b_from_adder;
   logic                  acc_en;

   // the adder only carries a negation for the operand that the select names
   assign a_from_adder = i_ctrl.load_from_adder && (i_ctrl.adder_sel == SEL_NEG_A);
   assign b_from_adder = i_ctrl.load_from_adder && (i_ctrl.adder_sel == SEL_NEG_B);
   assign acc_en       = i_ctrl.mul_step && areg[0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         q   <= '0;
         cnt <= '0;
      end else if (i_ctrl.clear) begin
         q   <= '0;
         cnt <= CNT_W'(DATA_WIDTH-1);
      end else begin
         if (i_ctrl.q_load || acc_en)
            q <= i_sum;
         if (i_ctrl.div_restore)
            q[cnt] <= 1'b1; // quotient bits fill from the top down
         if (i_ctrl.cnt_step)
            cnt <= i_sum[CNT_W-1:0];
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_ctrl.load_a)
         areg <= a_from_adder ? i_sum : i_a;
      else if (i_ctrl.mul_step)
         areg <= areg >> 1;

      if (i_ctrl.load_b)
         breg <= b_from_adder ? i_sum : i_b;
      else if (i_ctrl.mul_step)
         breg <= breg << 1;

      if (i_ctrl.clear)
         rem <= '0;
      else if (i_ctrl.div_shift)
         rem <= {rem[DATA_WIDTH-2:0], areg[cnt]};
      else if (i_ctrl.div_restore)
         rem <= i_sum;
   end

   assign o_status.a_neg       = i_a[DATA_WIDTH-1];
   assign o_status.b_neg       = i_b[DATA_WIDTH-1];
   assign o_status.a_rest_zero = (areg[DATA_WIDTH-1:1] == '0);
   // a set top bit only matters while multiplier bits are still to be added
   assign o_status.b_msb       = breg[DATA_WIDTH-1] && (areg != '0);
   assign o_status.adder_ovf   = i_sum_ovf && !(i_ctrl.mul_step && !areg[0]);
   assign o_status.adder_neg   = i_sum[DATA_WIDTH-1];
   assign o_status.cnt_zero    = (cnt == '0);

   assign o_areg = areg;
   assign o_breg = breg;
   assign o_rem  = rem;
   assign o_q    = q;
   assign o_cnt  = cnt;

endmodule

//--- src/alu_ctrl.sv
`timescale 1ns/1ps
module alu_ctrl import alu_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  alu_op_e    i_op,
   input  dp_status_t i_status,
   output dp_ctrl_t   o_ctrl,
   output logic       o_ovf,
   output logic       o_accept
);

   alu_state_e state_q;
   alu_state_e state_d;
   logic       res_neg_q;
   logic       res_neg_d;
   logic       is_mul_q;
   logic       is_mul_d;
   logic       accept_d;
   logic       ovf_d;
   logic       sub_ovf;
   logic       any_neg;

   // the adder sees a plus negated b, so the range check uses the raw signs
   assign sub_ovf = (i_status.a_neg != i_status.b_neg) &&
                    (i_status.adder_neg != i_status.a_neg);
   assign any_neg = i_status.a_neg || i_status.b_neg;

   always_comb begin
      o_ctrl    = '0;
      state_d   = state_q;
      res_neg_d = res_neg_q;
      is_mul_d  = is_mul_q;
      accept_d  = 1'b0;
      ovf_d     = 1'b0;

      case (state_q)
         ST_IDLE: begin
            // a request still held during the accept pulse is the old one
            if (!o_accept) begin
               case (i_op)
                  OP_ADD: begin
                     o_ctrl.adder_sel = SEL_ADD;
                     o_ctrl.q_load    = 1'b1;
                     accept_d         = 1'b1;
                     ovf_d            = i_status.adder_ovf;
                  end
                  OP_SUB: begin
                     o_ctrl.adder_sel = SEL_SUB;
                     o_ctrl.q_load    = 1'b1;
                     accept_d         = 1'b1;
                     ovf_d            = sub_ovf;
                  end
                  OP_MUL, OP_DIV: begin
                     o_ctrl.adder_sel       = i_status.a_neg ? SEL_NEG_A : SEL_NEG_B;
                     o_ctrl.clear           = 1'b1;
                     o_ctrl.load_a          = 1'b1;
                     o_ctrl.load_b          = 1'b1;
                     o_ctrl.load_from_adder = any_neg;
                     res_neg_d              = i_status.a_neg ^ i_status.b_neg;
                     is_mul_d               = (i_op == OP_MUL);
                     if (any_neg && i_status.adder_ovf) begin
                        accept_d = 1'b1; // most negative operand has no magnitude
                        ovf_d    = 1'b1;
                     end else if (i_status.a_neg && i_status.b_neg)
                        state_d = ST_SIGN_B;
                     else
                        state_d = (i_op == OP_MUL) ? ST_MUL : ST_DIV_SHIFT;
                  end
                  default: ;
               endcase
            end
         end
         ST_SIGN_B: begin
            o_ctrl.adder_sel       = SEL_NEG_B;
            o_ctrl.load_b          = 1'b1;
            o_ctrl.load_from_adder = 1'b1;
            if (i_status.adder_ovf) begin
               accept_d = 1'b1;
               ovf_d    = 1'b1;
               state_d  = ST_IDLE;
            end else
               state_d = is_mul_q ? ST_MUL : ST_DIV_SHIFT;
         end
         ST_MUL: begin
            o_ctrl.adder_sel = SEL_MUL_ACC;
            o_ctrl.mul_step  = 1'b1;
            if (i_status.adder_ovf || i_status.b_msb) begin
               accept_d = 1'b1;
               ovf_d    = 1'b1;
               state_d  = ST_IDLE;
            end else if (i_status.a_rest_zero) begin
               if (res_neg_q)
                  state_d = ST_SIGN_Q;
               else begin
                  accept_d = 1'b1;
                  state_d  = ST_IDLE;
               end
            end
         end
         ST_DIV_SHIFT: begin
            o_ctrl.div_shift = 1'b1;
            state_d          = ST_DIV_CMP;
         end
         ST_DIV_CMP: begin
            o_ctrl.adder_sel   = SEL_DIV_TRY;
            o_ctrl.div_restore = !i_status.adder_neg; // divisor fits into the remainder
            state_d            = ST_DIV_CNT;
         end
         ST_DIV_CNT: begin
            o_ctrl.adder_sel = SEL_CNT_DEC;
            if (i_status.cnt_zero) begin
               if (res_neg_q)
                  state_d = ST_SIGN_Q;
               else begin
                  accept_d = 1'b1;
                  state_d  = ST_IDLE;
               end
            end else begin
               o_ctrl.cnt_step = 1'b1;
               state_d         = ST_DIV_SHIFT;
            end
         end
         ST_SIGN_Q: begin
            o_ctrl.adder_sel = SEL_NEG_Q;
            o_ctrl.q_load    = 1'b1;
            accept_d         = 1'b1;
            state_d          = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q   <= ST_IDLE;
         res_neg_q <= 1'b0;
         is_mul_q  <= 1'b0;
         o_accept  <= 1'b0;
         o_ovf     <= 1'b0;
      end else begin
         state_q   <= state_d;
         res_neg_q <= res_neg_d;
         is_mul_q  <= is_mul_d;
         o_accept  <= accept_d;
         o_ovf     <= ovf_d;
      end
   end

endmodule

//--- src/sequential_alu.sv
`timescale 1ns/1ps
module sequential_alu import alu_pkg::*; #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  alu_op_e                      i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_accept
);

   localparam int CNT_W = $clog2(DATA_WIDTH);

   dp_ctrl_t                     ctrl;
   dp_status_t                   status;
   logic [DATA_WIDTH-1:0]        areg;
   logic [DATA_WIDTH-1:0]        breg;
   logic [DATA_WIDTH-1:0]        rem;
   logic [CNT_W-1:0]             cnt;
   logic signed [DATA_WIDTH-1:0] add_a;
   logic signed [DATA_WIDTH-1:0] add_b;
   logic signed [DATA_WIDTH-1:0] sum;
   logic                         sum_ovf;

   assign o_zero = (i_op == OP_DIV) && (i_b == '0);

   alu_ctrl ctrl_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_op     (i_op),
      .i_status (status),
      .o_ctrl   (ctrl),
      .o_ovf    (o_ovf),
      .o_accept (o_accept)
   );

   alu_operand_regs #(.DATA_WIDTH(DATA_WIDTH)) regs_i (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_ctrl    (ctrl),
      .i_a       (i_a),
      .i_b       (i_b),
      .i_sum     (sum),
      .i_sum_ovf (sum_ovf),
      .o_areg    (areg),
      .o_breg    (breg),
      .o_rem     (rem),
      .o_q       (o_q),
      .o_cnt     (cnt),
      .o_status  (status)
   );

   alu_adder_mux #(.DATA_WIDTH(DATA_WIDTH)) mux_i (
      .i_sel   (ctrl.adder_sel),
      .i_a     (i_a),
      .i_b     (i_b),
      .i_areg  (areg),
      .i_breg  (breg),
      .i_rem   (rem),
      .i_q     (o_q),
      .i_cnt   (cnt),
      .o_add_a (add_a),
      .o_add_b (add_b)
   );

   alu_adder #(.DATA_WIDTH(DATA_WIDTH)) adder_i (
      .i_a   (add_a),
      .i_b   (add_b),
      .o_q   (sum),
      .o_ovf (sum_ovf)
   );

endmodule

//--- tests/alu_asserts.sv
`timescale 1ns/1ps
module alu_asserts import alu_pkg::*; (
   input logic    i_clk,
   input logic    i_nrst,
   input alu_op_e i_op,
   input logic    i_ovf,
   input logic    i_accept
);

   // the result strobe is a single-cycle pulse
   accept_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_accept |=> !i_accept)
      else $error("o_accept stayed high for two consecutive cycles");

   ovf_with_accept: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_ovf |-> i_accept) // overflow is only reported as part of a result
      else $error("o_ovf is high without o_accept");

   // the request is held up to the edge that raises the pulse
   accept_needs_request: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_accept |-> ($past(i_op) != OP_NONE))
      else $error("o_accept pulsed although no operation was requested");

endmodule

bind sequential_alu alu_asserts asserts_i (
   .i_clk    (i_clk),
   .i_nrst   (i_nrst),
   .i_op     (i_op),
   .i_ovf    (o_ovf),
   .i_accept (o_accept)
);

//--- tests/alu_checker.sv
`timescale 1ns/1ps
module alu_checker import alu_pkg::*; #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  alu_op_e                      i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic signed [DATA_WIDTH-1:0] i_q,
   input  logic                         i_ovf,
   input  logic                         i_zero,
   input  logic                         i_accept,
   output int                           o_errors,
   output int                           o_checked
);

   localparam longint MAX_POS = (longint'(1) <<< (DATA_WIDTH-1)) - 1;
   localparam longint MIN_NEG = -(longint'(1) <<< (DATA_WIDTH-1));

   int                           err_count = 0;
   int                           checked = 0;
   logic                         pending = 1'b0;
   logic                         zero_exp;
   int                           cycles;
   alu_op_e                      req_op;
   logic signed [DATA_WIDTH-1:0] req_a;
   logic signed [DATA_WIDTH-1:0] req_b;

   assign o_errors  = err_count;
   assign o_checked = checked;

   task automatic report_value(input string msg);
      err_count++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   function automatic longint magnitude(input longint v);
      return (v < 0) ? -v : v;
   endfunction

   // a divide request with a zero divisor must raise the zero flag while it is held
   function automatic logic divides_by_zero(input alu_op_e op,
         input logic signed [DATA_WIDTH-1:0] vb);
      return (op == OP_DIV) && (vb == 0);
   endfunction

   // reference rules for signed add, subtract, multiply and divide
   function automatic void expect_result(input alu_op_e op, input longint ta, input longint tb,
         output logic [DATA_WIDTH-1:0] exp_q, output logic exp_ovf, output logic q_known);
      longint full;
      longint mag;
      full    = 0;
      q_known = 1'b1;
      exp_ovf = 1'b0;
      case (op)
         OP_ADD, OP_SUB: begin
            full    = (op == OP_ADD) ? ta + tb : ta - tb;
            exp_ovf = (full > MAX_POS) || (full < MIN_NEG);
         end
         OP_MUL: begin
            full    = ta * tb;
            exp_ovf = (ta == MIN_NEG) || (tb == MIN_NEG) || (magnitude(full) > MAX_POS);
            q_known = !exp_ovf;
         end
         OP_DIV: begin
            exp_ovf = (ta == MIN_NEG) || (tb == MIN_NEG);
            q_known = !exp_ovf && (tb != 0);
            if (tb != 0) begin
               mag  = magnitude(ta) / magnitude(tb); // truncates toward zero
               full = ((ta < 0) != (tb < 0)) ? -mag : mag;
            end
         end
         default: q_known = 1'b0;
      endcase
      exp_q = DATA_WIDTH'(full);
   endfunction

   task automatic check_result();
      logic [DATA_WIDTH-1:0] exp_q;
      logic                  exp_ovf;
      logic                  q_known;
      expect_result(req_op, longint'(req_a), longint'(req_b), exp_q, exp_ovf, q_known);
      checked++;
      if (i_ovf !== exp_ovf)
         report_value($sformatf("%s a=%0d b=%0d o_ovf=%b expected %b",
                                req_op.name(), req_a, req_b, i_ovf, exp_ovf));
      if (q_known && (i_q !== exp_q))
         report_value($sformatf("%s a=%0d b=%0d o_q=%0d expected %0d",
                                req_op.name(), req_a, req_b, i_q, $signed(exp_q)));
      if ((req_op == OP_ADD || req_op == OP_SUB) && cycles != 1)
         report_value($sformatf("%s took %0d cycles instead of 1", req_op.name(), cycles));
   endtask

   // inputs change just after the rising edge, so the falling edge sees them settled
   always @(negedge i_clk) begin
      if (!i_nrst) begin
         pending = 1'b0;
         if (i_accept || i_ovf || (i_q != '0))
            report_value("outputs not cleared while reset is held");
      end else begin
         zero_exp = 1'b0; // no request is held
         if (pending) begin
            zero_exp = divides_by_zero(req_op, req_b); // held up to and during the pulse
            if (i_accept) begin
               check_result();
               pending = 1'b0;
            end else
               cycles++;
         end else if (i_accept) begin
            err_count++;
            $display("unexpected o_accept at time %0t with no request pending", $time);
         end else if (i_op != OP_NONE) begin
            req_op   = i_op;
            req_a    = i_a;
            req_b    = i_b;
            cycles   = 1;
            pending  = 1'b1;
            zero_exp = divides_by_zero(req_op, req_b);
         end
         if (i_zero !== zero_exp)
            report_value($sformatf("o_zero=%b for %s with b=%0d", i_zero, i_op.name(), i_b));
      end
   end

endmodule

//--- tests/tb_sequential_alu.sv
`timescale 1ns/1ps
module tb_sequential_alu import alu_pkg::*;;

   localparam int DATA_WIDTH     = 16;
   localparam int NUM_REQ        = 400;
   localparam int RESET_CYCLES   = 8;
   localparam int ACCEPT_TIMEOUT = 200;
   localparam int SEED           = 37;

   logic                         clk;
   logic                         nrst;
   alu_op_e                      op;
   logic signed [DATA_WIDTH-1:0] a;
   logic signed [DATA_WIDTH-1:0] b;
   logic signed [DATA_WIDTH-1:0] q;
   logic                         ovf;
   logic                         zero;
   logic                         accept;
   int                           chk_errors;
   int                           chk_checked;
   int                           timeouts = 0;

   initial clk = 1'b0;
   always #2 clk = ~clk; // 4 ns period

   sequential_alu #(.DATA_WIDTH(DATA_WIDTH)) dut_i (
      .i_clk    (clk),
      .i_nrst   (nrst),
      .i_op     (op),
      .i_a      (a),
      .i_b      (b),
      .o_q      (q),
      .o_ovf    (ovf),
      .o_zero   (zero),
      .o_accept (accept)
   );

   alu_checker #(.DATA_WIDTH(DATA_WIDTH)) chk_i (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_op      (op),
      .i_a       (a),
      .i_b       (b),
      .i_q       (q),
      .i_ovf     (ovf),
      .i_zero    (zero),
      .i_accept  (accept),
      .o_errors  (chk_errors),
      .o_checked (chk_checked)
   );

   // corner values come up far more often than a uniform draw would give them
   function automatic logic signed [DATA_WIDTH-1:0] pick_operand();
      int unsigned kind;
      kind = $urandom % 8;
      case (kind)
         0: return '0;
         1: return '1;
         2: return {1'b1, {(DATA_WIDTH-1){1'b0}}};
         3: return {1'b0, {(DATA_WIDTH-1){1'b1}}};
         4, 5: return DATA_WIDTH'($urandom % 16) - DATA_WIDTH'(8);
         default: return DATA_WIDTH'($urandom);
      endcase
   endfunction

   task automatic run_request(input alu_op_e req, input logic signed [DATA_WIDTH-1:0] va,
         input logic signed [DATA_WIDTH-1:0] vb, output bit timed_out);
      int waited;
      @(posedge clk);
      #1;
      op = req;
      a  = va;
      b  = vb;
      waited    = 0;
      timed_out = 1'b0;
      @(negedge clk);
      while (!accept && waited < ACCEPT_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!accept) begin
         $display("timeout: no o_accept within %0d cycles of a %s request", waited, req.name());
         timed_out = 1'b1;
      end
      @(posedge clk);
      #1;
      op = OP_NONE;
   endtask

   task automatic report_and_finish();
      int missing;
      missing = NUM_REQ - chk_checked;
      $display("summary: %0d checker errors, %0d timeouts, %0d results missing",
               chk_errors, timeouts, missing);
      if (chk_errors == 0 && timeouts == 0 && missing == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   endtask

   initial begin
      bit                           timed_out;
      int                           n;
      alu_op_e                      req;
      logic signed [DATA_WIDTH-1:0] va;
      logic signed [DATA_WIDTH-1:0] vb;
      op   = OP_NONE;
      a    = '0;
      b    = '0;
      nrst = 1'b0;
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      nrst = 1'b1;
      for (n = 0; n < NUM_REQ && timeouts == 0; n++) begin
         req = alu_op_e'(3'($urandom % 4) + 3'd1);
         va  = pick_operand();
         vb  = pick_operand();
         run_request(req, va, vb, timed_out);
         if (timed_out)
            timeouts++;
         repeat ($urandom % 3) @(posedge clk);
      end
      repeat (2) @(posedge clk);
      report_and_finish();
   end

endmodule

//--- filelist.f
src/alu_pkg.sv
src/alu_adder.sv
src/alu_adder_mux.sv
src/alu_operand_regs.sv
src/alu_ctrl.sv
src/sequential_alu.sv
tests/alu_asserts.sv
tests/alu_checker.sv
tests/tb_sequential_alu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_sequential_alu -f filelist.f &&
./obj_dir/Vtb_sequential_alu | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
exit 0 || exit 1
